// File: Bender.yml
package:
  name: rdma_xmit

sources:
  - rdma_pkg.sv
  - stream_fifo.sv
  - packet_length_counter.sv
  - write_response.sv
  - rdma_header_builder.sv
  - tx_sequencer.sv
  - rdma_xmit.sv
  - target: test
    files:
      - tb_rdma_xmit.sv

// File: packet_length_counter.sv
// Strobe popcount and per-burst byte total, one length entry per burst
`timescale 1ns/1ns
`default_nettype none

module packet_length_counter import rdma_pkg::*; (
   input  logic                clk,
   input  logic                resetn,
   input  axis_beat_t          w_beat,
   input  logic                w_fire,
   output logic [len_bits-1:0] len_data,
   output logic                len_valid
);

   // Bytes in the current beat, 0 to 64
   logic [$clog2(stream_bytes+1)-1:0] beat_bytes;

   // Running total of earlier beats in this burst
   logic [len_bits-1:0] acc;

   // Count the set strobes
   always_comb begin
      beat_bytes = '0;
      for (int i = 0; i < stream_bytes; i++) begin
         beat_bytes = beat_bytes + w_beat.keep[i];
      end
   end

   // Total includes the last beat itself, so it is ready in the same cycle
   assign len_data  = acc + len_bits'(beat_bytes);
   assign len_valid = w_fire && w_beat.last;

   always_ff @(posedge clk) begin
      if (!resetn) begin
         acc <= '0;
      end else if (w_fire) begin
         // Clear on last so the next burst starts from zero
         if (w_beat.last)
            acc <= '0;
         else
            acc <= len_data;
      end
   end

endmodule

`default_nettype wire

// File: rdma_header_builder.sv
// Combinational RDMA header builder with IPv4 checksum and byte reversal
`timescale 1ns/1ns
`default_nettype none

module rdma_header_builder import rdma_pkg::*; (
   input  logic [len_bits-1:0]    payload_len,
   input  logic [addr_bits-1:0]   target_addr,
   output logic [stream_bits-1:0] hdr_data
);

   logic [len_bits-1:0] ip_len;
   logic [len_bits-1:0] udp_len;
   logic [31:0]         csum_sum;
   logic [16:0]         csum_fold1;
   logic [15:0]         csum_fold2;
   logic [15:0]         ip_csum;
   hdr_beat_u           hdr;

   // ==================================================
   // Lengths and checksum
   // ==================================================
   assign ip_len  = len_bits'(ip_hdr_len + udp_hdr_len + rdma_hdr_len) + payload_len;
   assign udp_len = len_bits'(udp_hdr_len + rdma_hdr_len) + payload_len;

   // Nine header words, checksum field itself counted as zero
   assign csum_sum = 32'(ip4_ver_dsf) + 32'(ip_len) + 32'(ip4_id) + 32'(ip4_flags)
                   + 32'(ip4_ttl_prot) + 32'(src_ip[31:16]) + 32'(src_ip[15:0])
                   + 32'(dst_ip[31:16]) + 32'(dst_ip[15:0]);

   // Fold carries back in twice, second fold cannot overflow
   assign csum_fold1 = {1'b0, csum_sum[15:0]} + {1'b0, csum_sum[31:16]};
   assign csum_fold2 = csum_fold1[15:0] + {15'h0, csum_fold1[16]};
   assign ip_csum    = ~csum_fold2;

   // ==================================================
   // Field view
   // ==================================================
   always_comb begin
      hdr.fields             = '0;
      hdr.fields.eth_dst     = eth_dst_mac;
      hdr.fields.eth_src     = eth_src_mac;
      hdr.fields.eth_type    = eth_type_ipv4;
      hdr.fields.ip_ver_dsf  = ip4_ver_dsf;
      hdr.fields.ip_len      = ip_len;
      hdr.fields.ip_id       = ip4_id;
      hdr.fields.ip_flags    = ip4_flags;
      hdr.fields.ip_ttl_prot = ip4_ttl_prot;
      hdr.fields.ip_csum     = ip_csum;
      hdr.fields.ip_src      = src_ip;
      hdr.fields.ip_dst      = dst_ip;
      hdr.fields.udp_src     = udp_src_port;
      hdr.fields.udp_dst     = udp_dst_port;
      hdr.fields.udp_len     = udp_len;
      hdr.fields.magic       = rdma_magic;
      hdr.fields.target_addr = target_addr;
      // UDP checksum and reserved bytes stay zero
   end

   // Byte view reversed, MAC sends data byte 0 first
   always_comb begin
      for (int i = 0; i < stream_bytes; i++) begin
         hdr_data[i*8 +: 8] = hdr.bytes[stream_bytes-1-i];
      end
   end

endmodule

`default_nettype wire

// File: rdma_pkg.sv
// Framer widths, FIFO depths, header constants, state codes, beat and header types
`default_nettype none

package rdma_pkg;

   // ==================================================
   // Widths and lengths
   // ==================================================
   localparam int stream_bytes = 64;
   localparam int stream_bits  = stream_bytes * 8;
   localparam int addr_bits    = 64;
   localparam int len_bits     = 16;

   // Fixed header sizes in bytes
   localparam int ip_hdr_len   = 20;
   localparam int udp_hdr_len  = 8;
   localparam int rdma_hdr_len = 22;

   // Buffer depths, payload in beats and packet info in entries
   localparam int data_fifo_depth = 32;
   localparam int pkt_fifo_depth  = 8;

   // ==================================================
   // Header constants
   // ==================================================
   localparam logic [47:0] eth_dst_mac   = 48'hffff_ffff_ffff;
   localparam logic [47:0] eth_src_mac   = 48'hc400_ad00_0002;
   localparam logic [15:0] eth_type_ipv4 = 16'h0800;

   // IPv4 words that never change
   localparam logic [15:0] ip4_ver_dsf  = 16'h4500;
   localparam logic [15:0] ip4_id       = 16'hdead;
   localparam logic [15:0] ip4_flags    = 16'h4000;
   localparam logic [15:0] ip4_ttl_prot = 16'h4011;
   localparam logic [31:0] src_ip       = 32'h0a01_0102;   // 10.1.1.2
   localparam logic [31:0] dst_ip       = 32'h0a01_01ff;   // 10.1.1.255

   // UDP ports and RDMA magic
   localparam logic [15:0] udp_src_port = 16'd1000;
   localparam logic [15:0] udp_dst_port = 16'd32002;
   localparam logic [15:0] rdma_magic   = 16'h0122;

   // Write response code
   localparam logic [1:0] resp_okay = 2'b00;

   // Output sequencer states
   localparam logic [1:0] st_init    = 2'd0;
   localparam logic [1:0] st_header  = 2'd1;
   localparam logic [1:0] st_payload = 2'd2;

   // ==================================================
   // Types
   // ==================================================
   typedef struct packed {
      logic [stream_bits-1:0]  data;
      logic [stream_bytes-1:0] keep;
      logic                    last;
   } axis_beat_t;

   // Header fields in wire order, first field in the top byte
   typedef struct packed {
      logic [47:0] eth_dst;
      logic [47:0] eth_src;
      logic [15:0] eth_type;
      logic [15:0] ip_ver_dsf;
      logic [15:0] ip_len;
      logic [15:0] ip_id;
      logic [15:0] ip_flags;
      logic [15:0] ip_ttl_prot;
      logic [15:0] ip_csum;
      logic [31:0] ip_src;
      logic [31:0] ip_dst;
      logic [15:0] udp_src;
      logic [15:0] udp_dst;
      logic [15:0] udp_len;
      logic [15:0] udp_csum;
      logic [15:0] magic;
      logic [63:0] target_addr;
      logic [95:0] reserved;
   } rdma_hdr_t;

   // Same 64 bytes as named fields or as raw bytes, bytes[63] is wire byte 0
   typedef union packed {
      rdma_hdr_t                    fields;
      logic [stream_bytes-1:0][7:0] bytes;
   } hdr_beat_u;

endpackage

`default_nettype wire

// File: rdma_xmit.sv
// Top level of the RDMA transmit framer, FIFOs and function blocks
`timescale 1ns/1ns
`default_nettype none

module rdma_xmit import rdma_pkg::*; (
   input  logic                 clk,
   input  logic                 resetn,
   // Write address channel
   input  logic [addr_bits-1:0] aw_addr,
   input  logic                 aw_valid,
   output logic                 aw_ready,
   // Write data channel, keep carries the strobes
   input  axis_beat_t           w_beat,
   input  logic                 w_valid,
   output logic                 w_ready,
   // Write response channel
   output logic [1:0]           b_resp,
   output logic                 b_valid,
   input  logic                 b_ready,
   // Output stream
   output axis_beat_t           tx_beat,
   output logic                 tx_valid,
   input  logic                 tx_ready
);

   // Address FIFO head
   logic [addr_bits-1:0]   addr_head;
   logic                   addr_head_valid;
   logic                   addr_head_ready;
   // Length FIFO input and head
   logic [len_bits-1:0]    len_in_data;
   logic                   len_in_valid;
   logic                   len_in_ready;
   logic [len_bits-1:0]    len_head;
   logic                   len_head_valid;
   logic                   len_head_ready;
   // Data FIFO
   logic                   data_in_ready;
   axis_beat_t             pay_beat;
   logic                   pay_valid;
   logic                   pay_ready;
   // Header path
   logic [addr_bits-1:0]   held_addr;
   logic [stream_bits-1:0] hdr_data;
   logic                   w_fire;

   // W stalls on a full data FIFO or a full length FIFO
   assign w_ready = data_in_ready && len_in_ready;
   assign w_fire  = w_valid && w_ready;

   // ==================================================
   // Buffers
   // ==================================================
   stream_fifo #(.width(addr_bits), .depth(pkt_fifo_depth)) addr_fifo (
      .clk, .resetn,
      .in_data(aw_addr), .in_valid(aw_valid), .in_ready(aw_ready),
      .out_data(addr_head), .out_valid(addr_head_valid), .out_ready(addr_head_ready)
   );

   stream_fifo #(.width(len_bits), .depth(pkt_fifo_depth)) len_fifo (
      .clk, .resetn,
      .in_data(len_in_data), .in_valid(len_in_valid), .in_ready(len_in_ready),
      .out_data(len_head), .out_valid(len_head_valid), .out_ready(len_head_ready)
   );

   // Write only when the length FIFO can also take the burst end
   stream_fifo #(.width($bits(axis_beat_t)), .depth(data_fifo_depth)) data_fifo (
      .clk, .resetn,
      .in_data(w_beat), .in_valid(w_valid && len_in_ready), .in_ready(data_in_ready),
      .out_data(pay_beat), .out_valid(pay_valid), .out_ready(pay_ready)
   );

   // ==================================================
   // Function blocks
   // ==================================================
   packet_length_counter len_count_i (
      .clk, .resetn, .w_beat, .w_fire,
      .len_data(len_in_data), .len_valid(len_in_valid)
   );

   // A length push marks a completed burst
   write_response resp_i (
      .clk, .resetn, .burst_done(len_in_valid), .b_resp, .b_valid, .b_ready
   );

   rdma_header_builder hdr_i (
      .payload_len(len_head), .target_addr(held_addr), .hdr_data
   );

   tx_sequencer seq_i (
      .clk, .resetn,
      .addr_data(addr_head), .addr_valid(addr_head_valid), .addr_ready(addr_head_ready),
      .len_valid(len_head_valid), .len_ready(len_head_ready),
      .pay_beat, .pay_valid, .pay_ready,
      .hdr_data, .held_addr,
      .tx_beat, .tx_valid, .tx_ready
   );

endmodule

`default_nettype wire

// File: stream_fifo.sv
// Synchronous valid/ready FIFO with parameterised width and depth
`timescale 1ns/1ns
`default_nettype none

module stream_fifo #(
   parameter int width = 8,
   parameter int depth = 8
) (
   input  logic             clk,
   input  logic             resetn,
   input  logic [width-1:0] in_data,
   input  logic             in_valid,
   output logic             in_ready,
   output logic [width-1:0] out_data,
   output logic             out_valid,
   input  logic             out_ready
);

   // Storage, no reset needed
   logic [width-1:0] mem [depth];

   logic [$clog2(depth)-1:0]   wr_ptr;
   logic [$clog2(depth)-1:0]   rd_ptr;
   logic [$clog2(depth+1)-1:0] count;
   logic [$clog2(depth+1)-1:0] count_next;
   logic                       push;
   logic                       pop;

   assign push = in_valid && in_ready;
   assign pop  = out_valid && out_ready;

   // Head entry is always on the output
   assign out_data  = mem[rd_ptr];
   assign out_valid = (count != 0);

   always_comb begin
      count_next = count;
      if (push && !pop)
         count_next = count + 1'b1;
      else if (pop && !push)
         count_next = count - 1'b1;
   end

   always_ff @(posedge clk) begin
      if (push)
         mem[wr_ptr] <= in_data;
   end

   // Pointers, count, and a registered ready that comes up after reset
   always_ff @(posedge clk) begin
      if (!resetn) begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         count    <= '0;
         in_ready <= 1'b0;
      end else begin
         count    <= count_next;
         in_ready <= (count_next != depth);
         if (push)
            wr_ptr <= (int'(wr_ptr) == depth - 1) ? '0 : wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= (int'(rd_ptr) == depth - 1) ? '0 : rd_ptr + 1'b1;
      end
   end

endmodule

`default_nettype wire

// File: tb.f
rdma_pkg.sv
stream_fifo.sv
packet_length_counter.sv
write_response.sv
rdma_header_builder.sv
tx_sequencer.sv
rdma_xmit.sv
tb_rdma_xmit.sv

// File: tb_rdma_xmit.sv
// Random-stimulus testbench for the RDMA transmit framer with reference model and checker
`timescale 1ns/1ns
`default_nettype none

module tb_rdma_xmit import rdma_pkg::*; ();

   localparam int num_packets    = 40;
   // 40 packets of up to 9 beats, about 50 cycles per beat under random stalls
   localparam int timeout_cycles = num_packets * 9 * 50 + 2000;

   logic                 clk;
   logic                 resetn;
   logic [addr_bits-1:0] aw_addr;
   logic                 aw_valid;
   logic                 aw_ready;
   axis_beat_t           w_beat;
   logic                 w_valid;
   logic                 w_ready;
   logic [1:0]           b_resp;
   logic                 b_valid;
   logic                 b_ready;
   axis_beat_t           tx_beat;
   logic                 tx_valid;
   logic                 tx_ready;

   // Model queues, filled before each packet is sent
   logic [stream_bits-1:0] exp_hdr_q[$];
   int                     exp_len_q[$];
   axis_beat_t             exp_beat_q[$];
   axis_beat_t             burst[$];

   int   errors = 0;
   int   checks = 0;
   int   tests = 0;
   int   cycles = 0;
   int   pkts_sent = 0;
   int   rx_pkts = 0;
   int   resp_count = 0;
   int   bursts_done = 0;
   int   stall_cycles = 0;
   int   pkt_err_start = 0;
   int   cur_len = 0;
   logic want_header = 1'b1;
   logic hold_tx = 1'b0;

   rdma_xmit dut_i (.*);

   initial clk = 1'b0;
   always #4 clk = ~clk;

   // ==================================================
   // Checker and header model
   // ==================================================
   task automatic check(input string what, input logic [511:0] exp, input logic [511:0] act);
      checks++;
      if (exp !== act) begin
         errors++;
         $display("FAILED %s: expected %0h, actual %0h", what, exp, act);
      end
   endtask

   // Field goes on the wire most significant byte first
   function automatic logic [511:0] put_bytes(input logic [511:0] h, input int pos,
                                              input int n, input logic [63:0] val);
      for (int i = 0; i < n; i++) begin
         h[(pos+i)*8 +: 8] = val[(n-1-i)*8 +: 8];
      end
      return h;
   endfunction

   function automatic logic [15:0] get_word(input logic [511:0] h, input int pos);
      return {h[pos*8 +: 8], h[(pos+1)*8 +: 8]};
   endfunction

   function automatic logic [511:0] model_header(input int len, input logic [63:0] addr);
      logic [511:0] h;
      logic [31:0]  sum;
      h = '0;
      h = put_bytes(h, 0, 6, 48'hffff_ffff_ffff);
      h = put_bytes(h, 6, 6, eth_src_mac);
      h = put_bytes(h, 12, 2, 16'h0800);
      // IPv4 header, wire bytes 14 to 33
      h = put_bytes(h, 14, 2, ip4_ver_dsf);
      h = put_bytes(h, 16, 2, 50 + len);
      h = put_bytes(h, 18, 2, ip4_id);
      h = put_bytes(h, 20, 2, ip4_flags);
      h = put_bytes(h, 22, 2, ip4_ttl_prot);
      h = put_bytes(h, 26, 4, 32'h0a01_0102);
      h = put_bytes(h, 30, 4, 32'h0a01_01ff);
      // UDP, magic and target address, checksum and reserved stay zero
      h = put_bytes(h, 34, 2, 16'd1000);
      h = put_bytes(h, 36, 2, 16'd32002);
      h = put_bytes(h, 38, 2, 30 + len);
      h = put_bytes(h, 42, 2, 16'h0122);
      h = put_bytes(h, 44, 8, addr);
      // Checksum over the IPv4 words with its own field still zero
      sum = 0;
      for (int i = 14; i < 34; i += 2) begin
         sum = sum + get_word(h, i);
      end
      sum = sum[15:0] + sum[31:16];
      sum = sum[15:0] + sum[31:16];
      h = put_bytes(h, 24, 2, ~sum[15:0]);
      return h;
   endfunction

   // ==================================================
   // Drivers, all changes 1 ns after the rising edge
   // ==================================================
   task automatic send_addr(input logic [63:0] addr);
      aw_addr  = addr;
      aw_valid = 1'b1;
      do @(negedge clk); while (!aw_ready);
      @(posedge clk);
      #1;
      aw_valid = 1'b0;
   endtask

   task automatic send_burst();
      foreach (burst[i]) begin
         // Occasional idle gap between beats
         if ($urandom % 4 == 0) begin
            w_valid = 1'b0;
            repeat ($urandom % 3 + 1) @(posedge clk);
            #1;
         end
         w_beat  = burst[i];
         w_valid = 1'b1;
         do @(negedge clk); while (!w_ready);
         @(posedge clk);
         #1;
      end
      w_valid = 1'b0;
   endtask

   // Sink readiness, held off for a long stretch mid-run
   always @(posedge clk) begin
      #1;
      tx_ready = hold_tx ? 1'b0 : (($urandom % 10) < 7);
      b_ready  = ($urandom % 2) == 1;
   end

   initial begin
      wait (pkts_sent >= 16);
      @(posedge clk);
      hold_tx = 1'b1;
      repeat (400) @(posedge clk);
      hold_tx = 1'b0;
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= timeout_cycles) begin
         $display("Timeout after %0d cycles with %0d of %0d packets received",
                  cycles, rx_pkts, num_packets);
         $display("CHECKS FAILED");
         $finish;
      end
   end

   // ==================================================
   // Monitors, sampled at the falling edge
   // ==================================================
   always @(negedge clk) begin
      logic [511:0] exp_h;
      axis_beat_t   exp_b;
      if (resetn && tx_valid && tx_ready) begin
         if (want_header) begin
            if (exp_hdr_q.size() == 0) begin
               errors++;
               $display("Header beat arrived with no packet outstanding");
            end else begin
               pkt_err_start = errors;
               exp_h   = exp_hdr_q.pop_front();
               cur_len = exp_len_q.pop_front();
               check($sformatf("packet %0d header", rx_pkts), exp_h, tx_beat.data);
               check($sformatf("packet %0d ip length", rx_pkts), 50 + cur_len,
                     get_word(tx_beat.data, 16));
               check($sformatf("packet %0d udp length", rx_pkts), 30 + cur_len,
                     get_word(tx_beat.data, 38));
               check($sformatf("packet %0d ip checksum", rx_pkts), get_word(exp_h, 24),
                     get_word(tx_beat.data, 24));
               check($sformatf("packet %0d header keep", rx_pkts), {64{1'b1}}, tx_beat.keep);
               check($sformatf("packet %0d header last", rx_pkts), 1'b0, tx_beat.last);
               want_header = 1'b0;
            end
         end else if (exp_beat_q.size() == 0) begin
            errors++;
            $display("Payload beat arrived with no payload outstanding");
         end else begin
            exp_b = exp_beat_q.pop_front();
            check($sformatf("packet %0d data", rx_pkts), exp_b.data, tx_beat.data);
            check($sformatf("packet %0d keep", rx_pkts), exp_b.keep, tx_beat.keep);
            check($sformatf("packet %0d last", rx_pkts), exp_b.last, tx_beat.last);
            if (exp_b.last) begin
               tests++;
               $display("packet %0d (%0d bytes): %s", rx_pkts, cur_len,
                        (errors == pkt_err_start) ? "passed" : "failed");
               rx_pkts++;
               want_header = 1'b1;
            end
         end
      end
   end

   // Responses are checked before counting a burst ending on the same edge
   always @(negedge clk) begin
      if (resetn) begin
         if (b_valid && b_ready) begin
            resp_count++;
            check("write response code", 2'b00, b_resp);
            if (resp_count > bursts_done) begin
               errors++;
               $display("Write response arrived before its burst completed");
            end
         end
         if (w_valid && w_ready && w_beat.last)
            bursts_done++;
         if (hold_tx && w_valid && !w_ready)
            stall_cycles++;
      end
   end

   // ==================================================
   // Main sequence
   // ==================================================
   initial begin
      int unsigned     seed_val;
      int              nbeats;
      int              nlast;
      int              len;
      int              err_mark;
      logic            addr_first;
      logic [63:0]     addr;
      axis_beat_t      beat;
      resetn   = 1'b0;
      aw_addr  = '0;
      aw_valid = 1'b0;
      w_beat   = '0;
      w_valid  = 1'b0;
      b_ready  = 1'b0;
      tx_ready = 1'b0;
      // Seed the generator once
      seed_val = $urandom(32'h1d54);

      // Outputs stay quiet through reset and just after it
      err_mark = errors;
      repeat (16) begin
         @(posedge clk);
         @(negedge clk);
         check("reset tx_valid", 1'b0, tx_valid);
         check("reset b_valid", 1'b0, b_valid);
         check("reset aw_ready", 1'b0, aw_ready);
         check("reset w_ready", 1'b0, w_ready);
      end
      @(posedge clk);
      #1;
      resetn = 1'b1;
      repeat (2) begin
         @(negedge clk);
         check("idle tx_valid", 1'b0, tx_valid);
         check("idle b_valid", 1'b0, b_valid);
      end
      // Input ready is up one cycle after reset ends
      check("ready after reset aw_ready", 1'b1, aw_ready);
      check("ready after reset w_ready", 1'b1, w_ready);
      tests++;
      $display("reset: %s", (errors == err_mark) ? "passed" : "failed");
      @(posedge clk);
      #1;

      for (int p = 0; p < num_packets; p++) begin
         nbeats     = 1 + $urandom % 8;
         nlast      = 1 + $urandom % 64;
         len        = (nbeats - 1) * 64 + nlast;
         addr       = {$urandom, $urandom};
         addr_first = $urandom % 2;
         burst.delete();
         for (int b = 0; b < nbeats; b++) begin
            for (int k = 0; k < 16; k++) begin
               beat.data[k*32 +: 32] = $urandom;
            end
            // Strobes packed from byte 0, only the last beat is partial
            beat.keep = (b == nbeats - 1) ? ({64{1'b1}} >> (64 - nlast)) : {64{1'b1}};
            beat.last = (b == nbeats - 1);
            burst.push_back(beat);
            exp_beat_q.push_back(beat);
         end
         exp_hdr_q.push_back(model_header(len, addr));
         exp_len_q.push_back(len);
         if (addr_first) begin
            send_addr(addr);
            send_burst();
         end else begin
            send_burst();
            send_addr(addr);
         end
         pkts_sent++;
      end

      wait (rx_pkts == num_packets && resp_count == num_packets);
      // Extra beats or responses would show up here
      repeat (50) @(posedge clk);

      err_mark = errors;
      check("response count", num_packets, resp_count);
      tests++;
      $display("responses: %s", (errors == err_mark) ? "passed" : "failed");

      err_mark = errors;
      check("leftover payload beats", 0, exp_beat_q.size());
      if (stall_cycles == 0) begin
         errors++;
         $display("w_ready never dropped while tx_ready was held low");
      end
      tests++;
      $display("back-pressure: %s", (errors == err_mark) ? "passed" : "failed");

      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// File: tx_sequencer.sv
// Output FSM emitting one header beat followed by the buffered payload beats
`timescale 1ns/1ns
`default_nettype none

module tx_sequencer import rdma_pkg::*; (
   input  logic                   clk,
   input  logic                   resetn,
   input  logic [addr_bits-1:0]   addr_data,
   input  logic                   addr_valid,
   output logic                   addr_ready,
   input  logic                   len_valid,
   output logic                   len_ready,
   input  axis_beat_t             pay_beat,
   input  logic                   pay_valid,
   output logic                   pay_ready,
   input  logic [stream_bits-1:0] hdr_data,
   output logic [addr_bits-1:0]   held_addr,
   output axis_beat_t             tx_beat,
   output logic                   tx_valid,
   input  logic                   tx_ready
);

   logic [1:0] state;
   logic       addr_held;
   logic       hdr_fire;
   logic       last_fire;

   // ==================================================
   // Handshakes
   // ==================================================
   // Take one address per packet, only while waiting in header
   assign addr_ready = (state == st_header) && !addr_held;

   // Length pops together with the header beat
   assign len_ready = (state == st_header) && addr_held && tx_ready;
   assign hdr_fire  = len_ready && len_valid;

   // Payload flows straight through in payload state
   assign pay_ready = (state == st_payload) && tx_ready;
   assign last_fire = pay_ready && pay_valid && pay_beat.last;

   // Output mux
   always_comb begin
      tx_beat  = '0;
      tx_valid = 1'b0;
      case (state)
         st_header: begin
            tx_beat.data = hdr_data;
            tx_beat.keep = '1;
            tx_valid     = addr_held && len_valid;
         end
         st_payload: begin
            tx_beat  = pay_beat;
            tx_valid = pay_valid;
         end
         default: begin
            tx_valid = 1'b0;
         end
      endcase
   end

   // Target address register, payload only
   always_ff @(posedge clk) begin
      if (addr_valid && addr_ready)
         held_addr <= addr_data;
   end

   // ==================================================
   // State machine
   // ==================================================
   always_ff @(posedge clk) begin
      if (!resetn) begin
         state     <= st_init;
         addr_held <= 1'b0;
      end else begin
         case (state)
            st_init: state <= st_header;
            st_header: begin
               if (addr_valid && addr_ready)
                  addr_held <= 1'b1;
               // Address is consumed by the header beat
               if (hdr_fire) begin
                  addr_held <= 1'b0;
                  state     <= st_payload;
               end
            end
            st_payload: begin
               if (last_fire)
                  state <= st_header;
            end
            default: state <= st_init;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: write_response.sv
// Write response channel driven by completed-burst and sent-response counters
`timescale 1ns/1ns
`default_nettype none

module write_response import rdma_pkg::*; (
   input  logic       clk,
   input  logic       resetn,
   input  logic       burst_done,
   output logic [1:0] b_resp,
   output logic       b_valid,
   input  logic       b_ready
);

   // Counts wrap together, so inequality means responses are owed
   logic [15:0] bursts_rcvd;
   logic [15:0] resps_sent;

   // Every burst is accepted
   assign b_resp  = resp_okay;
   assign b_valid = (bursts_rcvd != resps_sent);

   always_ff @(posedge clk) begin
      if (!resetn) begin
         bursts_rcvd <= '0;
         resps_sent  <= '0;
      end else begin
         if (burst_done)
            bursts_rcvd <= bursts_rcvd + 1'b1;
         // One response retired per handshake
         if (b_valid && b_ready)
            resps_sent <= resps_sent + 1'b1;
      end
   end

endmodule

`default_nettype wire
